/* hdl/histPkg.sv */
`default_nettype none

package histPkg;

    // timestamp width out of the TDC
    localparam int DEF_TS_BITS = 10;

    // bin index is the top bits of the timestamp, 64 bins
    localparam int DEF_BIN_BITS = 6;

    // per-bin count, saturates at all ones
    localparam int DEF_COUNT_BITS = 8;

    // accepted samples per frame
    localparam int DEF_FRAME_LEN = 300;

    // frame controller phases
    // CLEAR only runs once after reset, sweep without report
    typedef enum logic [2:0] {
        CLEAR,
        ACCUM,
        DRAIN,
        SWEEP,
        REPORT
    } histPhaseT;

endpackage

`default_nettype wire

/* hdl/ramPortIf.sv */
`default_nettype none

// one client's read and write port into the bin memory
interface ramPortIf #(
    parameter int BIN_BITS,
    parameter int COUNT_BITS
);
    // read side, data comes back one cycle after rdEn
    logic                  rdEn;
    logic [BIN_BITS-1:0]   rdAddr;
    logic [COUNT_BITS-1:0] rdData;

    // write side
    logic                  wrEn;
    logic [BIN_BITS-1:0]   wrAddr;
    logic [COUNT_BITS-1:0] wrData;

    modport client (output rdEn, rdAddr, wrEn, wrAddr, wrData, input rdData);
    modport mem (input rdEn, rdAddr, wrEn, wrAddr, wrData, output rdData);

endinterface

`default_nettype wire

/* hdl/binRam.sv */
`default_nettype none

module binRam #(
    parameter int BIN_BITS,
    parameter int COUNT_BITS
) (
    input  logic    clk,
    ramPortIf.mem   accPort,
    ramPortIf.mem   scanPort,
    input  logic    sweepOwns
);
    logic [COUNT_BITS-1:0] mem [0:(1 << BIN_BITS) - 1];

    logic                  rdEn;
    logic                  wrEn;
    logic [BIN_BITS-1:0]   rdAddr;
    logic [BIN_BITS-1:0]   wrAddr;
    logic [COUNT_BITS-1:0] wrData;
    logic [COUNT_BITS-1:0] rdQ;

    // scanner owns both ports during a sweep
    assign rdEn   = sweepOwns ? scanPort.rdEn   : accPort.rdEn;
    assign rdAddr = sweepOwns ? scanPort.rdAddr : accPort.rdAddr;
    assign wrEn   = sweepOwns ? scanPort.wrEn   : accPort.wrEn;
    assign wrAddr = sweepOwns ? scanPort.wrAddr : accPort.wrAddr;
    assign wrData = sweepOwns ? scanPort.wrData : accPort.wrData;

    // registered read, same-address write in the same cycle gives old data
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdQ <= mem[rdAddr];
        end
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign accPort.rdData  = rdQ;
    assign scanPort.rdData = rdQ;

endmodule

`default_nettype wire

/* hdl/histAccumulator.sv */
`default_nettype none

module histAccumulator #(
    parameter int TS_BITS,
    parameter int BIN_BITS,
    parameter int COUNT_BITS
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               accept,
    input  logic [TS_BITS-1:0] sample,
    ramPortIf.client           ramPort,
    output logic               busy
);
    // stage 0 is the accept cycle itself, read goes out right away
    logic [BIN_BITS-1:0]   bin0;

    // stage 1: ram data on rdData this cycle
    logic                  v1;
    logic [BIN_BITS-1:0]   bin1;

    // stage 2: incremented count, written at the end of this cycle
    logic                  v2;
    logic [BIN_BITS-1:0]   bin2;
    logic [COUNT_BITS-1:0] cnt2;

    // stage 3: value just written, ram read in flight missed it
    logic                  v3;
    logic [BIN_BITS-1:0]   bin3;
    logic [COUNT_BITS-1:0] cnt3;

    logic [COUNT_BITS-1:0] base;
    logic [COUNT_BITS-1:0] incr;

    // bin index from the upper timestamp bits
    assign bin0 = sample[TS_BITS-1 -: BIN_BITS];

    assign ramPort.rdEn   = accept;
    assign ramPort.rdAddr = bin0;

    // forwarding, newest write first
    always_comb begin
        if (v2 && bin2 == bin1) begin
            base = cnt2;
        end else if (v3 && bin3 == bin1) begin
            base = cnt3;
        end else begin
            base = ramPort.rdData;
        end
    end

    // hold at full scale
    assign incr = (base == '1) ? base : base + 1'b1;

    assign ramPort.wrEn   = v2;
    assign ramPort.wrAddr = bin2;
    assign ramPort.wrData = cnt2;

    // valid chain
    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= accept;
            v2 <= v1;
            v3 <= v2;
        end
    end

    // payload, qualified by the valid chain
    always_ff @(posedge clk) begin
        bin1 <= bin0;
        bin2 <= bin1;
        cnt2 <= incr;
        bin3 <= bin2;
        cnt3 <= cnt2;
    end

    // stage 3 included so a frame never ends with a write still fresh
    assign busy = v1 || v2 || v3;

endmodule

`default_nettype wire

/* hdl/peakScanner.sv */
`default_nettype none

module peakScanner #(
    parameter int BIN_BITS,
    parameter int COUNT_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    ramPortIf.client              ramPort,
    output logic                  done,
    output logic [BIN_BITS-1:0]   maxBin,
    output logic [COUNT_BITS-1:0] maxCount
);
    logic                active;
    logic                rdEn;
    logic [BIN_BITS-1:0] addr;
    logic [BIN_BITS-1:0] rdAddr;

    // read data returns with these
    logic                rdValid;
    logic                rdLast;
    logic [BIN_BITS-1:0] rdBin;

    // zero write one cycle after data
    logic                wrPend;
    logic [BIN_BITS-1:0] wrBin;

    // bin 0 is read in the start cycle itself
    assign rdEn   = start || active;
    assign rdAddr = start ? '0 : addr;

    assign ramPort.rdEn   = rdEn;
    assign ramPort.rdAddr = rdAddr;
    assign ramPort.wrEn   = wrPend;
    assign ramPort.wrAddr = wrBin;
    assign ramPort.wrData = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            rdValid <= 1'b0;
            wrPend  <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (start) begin
                active <= 1'b1;
            end else if (active && addr == '1) begin
                // last bin issued
                active <= 1'b0;
            end
            rdValid <= rdEn;
            wrPend  <= rdValid;
            done    <= rdValid && rdLast;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            addr <= rdAddr + 1'b1;
        end
        rdBin  <= rdAddr;
        rdLast <= (rdAddr == '1);
        wrBin  <= rdBin;
        // strictly greater only, so ties keep the lower bin
        if (start) begin
            maxBin   <= '0;
            maxCount <= '0;
        end else if (rdValid && ramPort.rdData > maxCount) begin
            maxBin   <= rdBin;
            maxCount <= ramPort.rdData;
        end
    end

endmodule

`default_nettype wire

/* hdl/histFsm.sv */
`default_nettype none

module histFsm #(
    parameter int BIN_BITS,
    parameter int COUNT_BITS,
    parameter int FRAME_LEN
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sampleValid,
    input  logic                  busy,
    input  logic                  done,
    input  logic [BIN_BITS-1:0]   maxBin,
    input  logic [COUNT_BITS-1:0] maxCount,
    input  logic                  peakAck,
    output logic                  sampleReady,
    output logic                  accept,
    output logic                  start,
    output logic                  sweepOwns,
    output logic                  peakReq,
    output logic [BIN_BITS-1:0]   peakBin,
    output logic [COUNT_BITS-1:0] peakCount
);
    import histPkg::*;

    localparam int CNT_BITS = $clog2(FRAME_LEN + 1);

    histPhaseT           phase;
    logic                started;
    logic [CNT_BITS-1:0] sampleCnt;

    assign sampleReady = (phase == ACCUM);
    assign accept      = sampleValid && sampleReady;
    assign sweepOwns   = (phase == CLEAR) || (phase == SWEEP);
    // one pulse at the top of each sweep
    assign start       = sweepOwns && !started;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= CLEAR;
            started   <= 1'b0;
            sampleCnt <= '0;
            peakReq   <= 1'b0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            case (phase)
                // power-up clear, no report
                CLEAR: if (done) begin
                    started <= 1'b0;
                    phase   <= ACCUM;
                end
                ACCUM: if (accept) begin
                    if (sampleCnt == CNT_BITS'(FRAME_LEN - 1)) begin
                        sampleCnt <= '0;
                        phase     <= DRAIN;
                    end else begin
                        sampleCnt <= sampleCnt + 1'b1;
                    end
                end
                // wait out the increment pipeline
                DRAIN: if (!busy) begin
                    phase <= SWEEP;
                end
                SWEEP: if (done) begin
                    started <= 1'b0;
                    peakReq <= 1'b1;
                    phase   <= REPORT;
                end
                // four-phase, ready returns once ack is back low
                REPORT: if (peakReq && peakAck) begin
                    peakReq <= 1'b0;
                end else if (!peakReq && !peakAck) begin
                    phase <= ACCUM;
                end
                default: phase <= CLEAR;
            endcase
        end
    end

    // result held through the whole report
    always_ff @(posedge clk) begin
        if (phase == SWEEP && done) begin
            peakBin   <= maxBin;
            peakCount <= maxCount;
        end
    end

endmodule

`default_nettype wire

/* hdl/histTop.sv */
`default_nettype none

module histTop #(
    parameter int TS_BITS    = histPkg::DEF_TS_BITS,
    parameter int BIN_BITS   = histPkg::DEF_BIN_BITS,
    parameter int COUNT_BITS = histPkg::DEF_COUNT_BITS,
    parameter int FRAME_LEN  = histPkg::DEF_FRAME_LEN
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sampleValid,
    input  logic [TS_BITS-1:0]    sample,
    input  logic                  peakAck,
    output logic                  sampleReady,
    output logic                  peakReq,
    output logic [BIN_BITS-1:0]   peakBin,
    output logic [COUNT_BITS-1:0] peakCount
);
    logic                  accept;
    logic                  busy;
    logic                  start;
    logic                  done;
    logic                  sweepOwns;
    logic [BIN_BITS-1:0]   maxBin;
    logic [COUNT_BITS-1:0] maxCount;

    // memory ports, one per client
    ramPortIf #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)) accPort ();
    ramPortIf #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)) scanPort ();

    histFsm #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .FRAME_LEN(FRAME_LEN)) histFsm_i (
        .clk, .rst, .sampleValid, .busy, .done, .maxBin, .maxCount, .peakAck,
        .sampleReady, .accept, .start, .sweepOwns, .peakReq, .peakBin, .peakCount
    );

    histAccumulator #(.TS_BITS(TS_BITS), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS))
        histAccumulator_i (
        .clk, .rst, .accept, .sample, .ramPort(accPort.client), .busy
    );

    peakScanner #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)) peakScanner_i (
        .clk, .rst, .start, .ramPort(scanPort.client), .done, .maxBin, .maxCount
    );

    // scanner takes the memory in CLEAR and SWEEP
    binRam #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)) binRam_i (
        .clk, .accPort(accPort.mem), .scanPort(scanPort.mem), .sweepOwns
    );

endmodule

`default_nettype wire

/* dv/histTop_asserts.sv */
`default_nettype none

module histTopAsserts #(
    parameter int BIN_BITS   = histPkg::DEF_BIN_BITS,
    parameter int COUNT_BITS = histPkg::DEF_COUNT_BITS
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  sampleReady,
    input logic                  peakReq,
    input logic                  peakAck,
    input logic [BIN_BITS-1:0]   peakBin,
    input logic [COUNT_BITS-1:0] peakCount,
    input histPkg::histPhaseT    phase
);
    timeunit 1ns;
    timeprecision 1ps;

    import histPkg::*;

    // req only comes down after the ack
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        peakReq && !peakAck |=> peakReq)
        else $error("peakReq dropped before peakAck");

    // report payload frozen during the request
    resultStable: assert property (@(posedge clk) disable iff (rst)
        peakReq |=> !peakReq || ($stable(peakBin) && $stable(peakCount)))
        else $error("peak result changed while peakReq was high");

    // no samples taken while a report is open
    noReadyInReport: assert property (@(posedge clk) disable iff (rst)
        peakReq |-> !sampleReady)
        else $error("sampleReady high while peakReq was high");

    reqOnlyInReport: assert property (@(posedge clk) disable iff (rst)
        peakReq |-> phase == REPORT)
        else $error("peakReq high outside the report phase");

    // next frame opens only once ack is back low
    readyAfterAck: assert property (@(posedge clk) disable iff (rst)
        sampleReady |-> !peakAck)
        else $error("sampleReady high while peakAck was high");

    reqLowAfterReset: assert property (@(posedge clk)
        rst |=> !peakReq)
        else $error("peakReq high in the cycle after reset");

endmodule

`default_nettype wire

/* dv/histTb.sv */
`default_nettype none

module histTb;
    timeunit 1ns;
    timeprecision 1ps;

    import histPkg::*;

    localparam int TS_BITS        = DEF_TS_BITS;
    localparam int BIN_BITS       = DEF_BIN_BITS;
    localparam int COUNT_BITS     = DEF_COUNT_BITS;
    localparam int FRAME_LEN      = DEF_FRAME_LEN;
    localparam int NUM_BINS       = 1 << BIN_BITS;
    localparam int MAX_COUNT      = (1 << COUNT_BITS) - 1;
    localparam int NUM_FRAMES     = 7;
    localparam int READY_TIMEOUT  = 200;
    localparam int FRAME_TIMEOUT  = 2000;
    localparam int REPORT_TIMEOUT = 3000;
    // cycles before ack rises, and cycles ack stays up after req falls
    localparam int ACK_DELAY      = 3;
    localparam int ACK_HOLD       = 3;

    // stimulus kinds
    localparam int MODE_GAPS  = 0;
    localparam int MODE_HELD  = 1;
    localparam int MODE_BURST = 2;
    localparam int MODE_PAIRS = 3;
    localparam int MODE_SAT   = 4;

    logic                  clk;
    logic                  rst;
    logic                  sampleValid;
    logic [TS_BITS-1:0]    sample;
    logic                  peakAck;
    logic                  sampleReady;
    logic                  peakReq;
    logic [BIN_BITS-1:0]   peakBin;
    logic [COUNT_BITS-1:0] peakCount;

    logic [31:0]           lfsrState;
    logic [BIN_BITS-1:0]   frameBins [0:FRAME_LEN-1];
    logic [BIN_BITS-1:0]   expBin [$];
    logic [COUNT_BITS-1:0] expCount [$];
    int                    reportsSeen;

    histTop #(
        .TS_BITS(TS_BITS), .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .FRAME_LEN(FRAME_LEN)
    ) histTop_i (
        .clk, .rst, .sampleValid, .sample, .peakAck,
        .sampleReady, .peakReq, .peakBin, .peakCount
    );

    bind histTop histTopAsserts #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS)) histTopAsserts_i (
        .clk, .rst, .sampleReady, .peakReq, .peakAck, .peakBin, .peakCount,
        .phase(histFsm_i.phase)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopOnFailure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stopOnFailure();
        end
    endtask

    // right-shift Galois form, taps x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic takeBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // expected peak straight from the frame's recorded bins
    function automatic void histRef(output logic [BIN_BITS-1:0] bin,
                                    output logic [COUNT_BITS-1:0] count);
        int counts [0:NUM_BINS-1];
        int best;
        int bestBin;
        for (int b = 0; b < NUM_BINS; b++) begin
            counts[b] = 0;
        end
        for (int i = 0; i < FRAME_LEN; i++) begin
            if (counts[frameBins[i]] < MAX_COUNT) begin
                counts[frameBins[i]]++;
            end
        end
        best = 0;
        bestBin = 0;
        // scan upward, strict compare keeps the lower bin on a tie
        for (int b = 0; b < NUM_BINS; b++) begin
            if (counts[b] > best) begin
                best = counts[b];
                bestBin = b;
            end
        end
        bin = BIN_BITS'(bestBin);
        count = COUNT_BITS'(best);
    endfunction

    // low timestamp bits stay random in every mode
    task automatic pickSample(input int mode, input int n, output logic [TS_BITS-1:0] ts);
        logic [31:0]         r;
        logic [BIN_BITS-1:0] bin;
        takeBits(TS_BITS, r);
        ts = r[TS_BITS-1:0];
        bin = ts[TS_BITS-1 -: BIN_BITS];
        case (mode)
            // single-bin burst then alternating pair
            MODE_BURST: begin
                if (n < 150) begin
                    bin = BIN_BITS'(41);
                end else if (n % 2 == 1) begin
                    bin = BIN_BITS'(12);
                end else begin
                    bin = BIN_BITS'(13);
                end
            end
            // upper bin first, equal counts at the end
            MODE_PAIRS: bin = (n % 2 == 1) ? BIN_BITS'(12) : BIN_BITS'(13);
            MODE_SAT:   bin = BIN_BITS'(57);
            default:    bin = ts[TS_BITS-1 -: BIN_BITS];
        endcase
        ts = {bin, ts[TS_BITS-BIN_BITS-1:0]};
    endtask

    // offers samples until FRAME_LEN are taken, then queues the expected peak
    task automatic runFrame(input int mode);
        logic [31:0]           r;
        logic [TS_BITS-1:0]    ts;
        logic                  v;
        logic [BIN_BITS-1:0]   eBin;
        logic [COUNT_BITS-1:0] eCount;
        int                    n;
        int                    cycles;
        n = 0;
        cycles = 0;
        while (n < FRAME_LEN) begin
            @(negedge clk);
            if (cycles == FRAME_TIMEOUT) begin
                $display("timeout: frame %0d took only %0d samples by %0d ns",
                         reportsSeen, n, $time);
                stopOnFailure();
            end
            cycles++;
            pickSample(mode, n, ts);
            v = 1'b1;
            // about one cycle in four left idle
            if (mode == MODE_GAPS) begin
                takeBits(2, r);
                v = (r[1:0] != 2'b00);
            end
            sample = ts;
            sampleValid = v;
            // ready is settled since the last rising edge
            if (v && sampleReady) begin
                frameBins[n] = ts[TS_BITS-1 -: BIN_BITS];
                n++;
            end
        end
        histRef(eBin, eCount);
        expBin.push_back(eBin);
        expCount.push_back(eCount);
    endtask

    initial begin : compareReports
        int                    waitCycles;
        logic [BIN_BITS-1:0]   eBin;
        logic [COUNT_BITS-1:0] eCount;
        peakAck = 1'b0;
        reportsSeen = 0;
        while (reportsSeen < NUM_FRAMES) begin
            waitCycles = 0;
            while (peakReq !== 1'b1) begin
                @(negedge clk);
                if (waitCycles == REPORT_TIMEOUT) begin
                    $display("timeout: no peakReq for report %0d at %0d ns", reportsSeen, $time);
                    stopOnFailure();
                end
                waitCycles++;
            end
            if (expBin.size() == 0) begin
                $display("peakReq raised at %0d ns with no finished frame", $time);
                stopOnFailure();
            end
            eBin = expBin.pop_front();
            eCount = expCount.pop_front();
            checkValue(32'(peakBin), 32'(eBin), "peakBin");
            checkValue(32'(peakCount), 32'(eCount), "peakCount");
            // req has to stay up on its own until the ack comes
            repeat (ACK_DELAY) begin
                @(negedge clk);
                checkValue(32'(peakReq), 32'd1, "peakReq before peakAck");
            end
            peakAck = 1'b1;
            waitCycles = 0;
            while (peakReq !== 1'b0) begin
                @(negedge clk);
                if (waitCycles == REPORT_TIMEOUT) begin
                    $display("timeout: peakReq never dropped after peakAck at %0d ns", $time);
                    stopOnFailure();
                end
                waitCycles++;
            end
            // ack lingers, next frame must stay closed until it falls
            repeat (ACK_HOLD) begin
                @(negedge clk);
                checkValue(32'(sampleReady), 32'd0, "sampleReady while peakAck high");
            end
            peakAck = 1'b0;
            reportsSeen++;
        end
    end

    initial begin : mainSequence
        int waitCycles;
        lfsrState = 32'he9f4_3375;
        rst = 1'b1;
        sampleValid = 1'b0;
        sample = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue(32'(sampleReady), 32'd0, "sampleReady after reset");
        checkValue(32'(peakReq), 32'd0, "peakReq after reset");

        // clear sweep runs first, no report expected
        waitCycles = 0;
        while (sampleReady !== 1'b1) begin
            @(negedge clk);
            if (waitCycles == READY_TIMEOUT) begin
                $display("timeout: sampleReady never rose after reset");
                stopOnFailure();
            end
            waitCycles++;
        end

        // held modes keep valid high while the previous frame drains and reports
        runFrame(MODE_GAPS);
        runFrame(MODE_GAPS);
        runFrame(MODE_HELD);
        runFrame(MODE_BURST);
        runFrame(MODE_PAIRS);
        runFrame(MODE_SAT);
        runFrame(MODE_HELD);
        @(negedge clk);
        sampleValid = 1'b0;

        waitCycles = 0;
        while (reportsSeen < NUM_FRAMES) begin
            @(negedge clk);
            if (waitCycles == REPORT_TIMEOUT) begin
                $display("timeout: only %0d of %0d reports seen", reportsSeen, NUM_FRAMES);
                stopOnFailure();
            end
            waitCycles++;
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/histPkg.sv
hdl/ramPortIf.sv
hdl/binRam.sv
hdl/histAccumulator.sv
hdl/peakScanner.sv
hdl/histFsm.sv
hdl/histTop.sv
dv/histTop_asserts.sv
dv/histTb.sv

/* Makefile */
# Verilator build and run of the histogrammer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module histTb -Mdir obj_dir -f src.f
	./obj_dir/VhistTb | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
